// ==== dv/tb_tluh_reg.sv ====
module tb_tluh_reg import tluh_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  typedef logic [8*12-1:0] name_t;  // Test name, up to 12 characters

  logic       clk_i;
  logic       rst_ni;
  logic       a_valid_i;
  tl_a_op_e   a_opcode_i;
  logic [2:0] a_param_i;
  tl_size_t   a_size_i;
  tl_source_t a_source_i;
  tl_addr_t   a_address_i;
  tl_mask_t   a_mask_i;
  tl_data_t   a_data_i;
  logic       a_ready_o;
  logic       d_valid_o;
  tl_d_op_e   d_opcode_o;
  tl_size_t   d_size_o;
  tl_source_t d_source_o;
  tl_data_t   d_data_o;
  logic       d_error_o;
  logic       d_ready_i;

  // Request beats and expected response beats, in file order
  logic [31:0] a_op_q[$], a_par_q[$], a_size_q[$], a_src_q[$];
  logic [31:0] a_addr_q[$], a_mask_q[$], a_data_q[$];
  name_t       d_name_q[$];
  logic [31:0] d_op_q[$], d_err_q[$], d_data_q[$];
  logic [31:0] echo_src_q[$], echo_size_q[$];  // Source and size each D beat must echo

  int     n_a_beats = 0;
  int     n_d_beats = 0;
  int     d_idx = 0;
  int     errors = 0;
  int     timeout_cycles = 0;
  logic   loaded = 1'b0;
  logic   load_ok;
  integer seed = 32'hb6439983;

  tluh_reg_top tluh_reg_top_i (
    .clk_i, .rst_ni,
    .a_valid_i, .a_opcode_i, .a_param_i, .a_size_i, .a_source_i,
    .a_address_i, .a_mask_i, .a_data_i, .a_ready_o,
    .d_valid_o, .d_opcode_o, .d_size_o, .d_source_o, .d_data_o, .d_error_o, .d_ready_i
  );

  always #4 clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  task automatic check_value(input name_t tname, input string field,
                             input logic [31:0] exp_v, input logic [31:0] act_v);
    if (exp_v !== act_v) begin
      errors++;
      $display("ERROR %0s %0s: expected %h, actual %h", tname, field, exp_v, act_v);
    end
  endtask

  task automatic load_cases();
    int               fd;
    int               n;
    int               bad_lines;
    int               remaining;
    int               beats;
    int               d_beats;
    logic [8*128-1:0] line;
    logic [7:0]       kind;
    name_t            tname;
    logic [31:0]      op, par, size, src, addr, mask, data, err;
    load_ok   = 1'b0;
    remaining = 0;
    bad_lines = 0;
    fd = $fopen("dv/tluh_reg_cases.txt", "r");
    if (fd != 0) begin
      while ($fgets(line, fd) != 0) begin
        kind = '0;
        n = $sscanf(line, "%s", kind);
        if (kind == "A") begin
          n = $sscanf(line, "%s %s %h %h %h %h %h %h %h",
                      kind, tname, op, par, size, src, addr, mask, data);
          if (n != 9) begin
            bad_lines++;
          end
          a_op_q.push_back(op);
          a_par_q.push_back(par);
          a_size_q.push_back(size);
          a_src_q.push_back(src);
          a_addr_q.push_back(addr);
          a_mask_q.push_back(mask);
          a_data_q.push_back(data);
          if (remaining == 0) begin
            // First beat of a request sets how many D beats echo it
            beats = 1;
            if (op == 32'(Get) || op == 32'(PutFullData) || op == 32'(PutPartialData)) begin
              beats = (size == 3) ? 2 : (size == 4) ? 4 : 1;
            end
            d_beats = (op == 32'(Get)) ? beats : 1;  // Puts answer once
            repeat (d_beats) begin
              echo_src_q.push_back(src);
              echo_size_q.push_back(size);
            end
            remaining = (op == 32'(Get)) ? 0 : beats - 1;  // A Get burst is one A beat
          end else begin
            remaining--;
          end
        end else if (kind == "D") begin
          n = $sscanf(line, "%s %s %h %h %h", kind, tname, op, err, data);
          if (n != 5) begin
            bad_lines++;
          end
          d_name_q.push_back(tname);
          d_op_q.push_back(op);
          d_err_q.push_back(err);
          d_data_q.push_back(data);
        end
      end
      $fclose(fd);
      n_a_beats = a_op_q.size();
      n_d_beats = d_name_q.size();
      load_ok   = (n_a_beats > 0) && (n_d_beats == echo_src_q.size()) && (remaining == 0) &&
                  (bad_lines == 0);
    end
  endtask

  // Called on a rising edge, returns on the edge that takes the beat
  task automatic send_beat(input int i);
    a_valid_i   <= 1'b1;
    a_opcode_i  <= tl_a_op_e'(a_op_q[i][2:0]);
    a_param_i   <= a_par_q[i][2:0];
    a_size_i    <= a_size_q[i][2:0];
    a_source_i  <= a_src_q[i][3:0];
    a_address_i <= a_addr_q[i];
    a_mask_i    <= a_mask_q[i][3:0];
    a_data_i    <= a_data_q[i];
    @(negedge clk_i);
    while (!a_ready_o) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
  endtask

  task automatic check_d_beat();
    if (d_idx >= n_d_beats) begin
      errors++;
      $display("D beat from source %0h arrived after the last expected beat", d_source_o);
    end else begin
      check_value(d_name_q[d_idx], "opcode", d_op_q[d_idx], 32'(d_opcode_o));
      check_value(d_name_q[d_idx], "error", d_err_q[d_idx], 32'(d_error_o));
      if (d_op_q[d_idx] == 32'(AccessAckData)) begin
        check_value(d_name_q[d_idx], "data", d_data_q[d_idx], d_data_o);
      end
      check_value(d_name_q[d_idx], "source", echo_src_q[d_idx], 32'(d_source_o));
      check_value(d_name_q[d_idx], "size", echo_size_q[d_idx], 32'(d_size_o));
      d_idx++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Processes
  ////////////////////////////////////////////////////////////

  initial begin : main
    clk_i       = 1'b0;
    rst_ni      = 1'b0;
    a_valid_i   = 1'b0;
    a_opcode_i  = Get;
    a_param_i   = '0;
    a_size_i    = '0;
    a_source_i  = '0;
    a_address_i = '0;
    a_mask_i    = '0;
    a_data_i    = '0;
    d_ready_i   = 1'b0;
    load_cases();
    if (!load_ok) begin
      $display("cases file dv/tluh_reg_cases.txt is missing or inconsistent");
      $display("test failed");
      $finish;
    end else begin
      timeout_cycles = (n_a_beats + n_d_beats) * 50;
      loaded = 1'b1;
      repeat (2) @(posedge clk_i);
      rst_ni <= 1'b1;
      @(posedge clk_i);
      for (int i = 0; i < n_a_beats; i++) begin
        send_beat(i);
      end
      a_valid_i <= 1'b0;
      wait (d_idx == n_d_beats);
      repeat (20) @(posedge clk_i);  // Room for a stray extra D beat
      $display("%0d errors, %0d of %0d D beats checked", errors, d_idx, n_d_beats);
      if (errors == 0) begin
        $display("test passed");
      end else begin
        $display("test failed");
      end
      $finish;
    end
  end

  // Random stalls, roughly one cycle in four
  initial begin : d_monitor
    wait (rst_ni === 1'b1);
    forever begin
      @(posedge clk_i);
      d_ready_i <= ($random(seed) & 3) != 0;
      @(negedge clk_i);
      if (d_valid_o && d_ready_i) begin
        check_d_beat();  // Transfers on the next rising edge
      end
    end
  end

  initial begin : watchdog
    wait (loaded);
    repeat (timeout_cycles) @(posedge clk_i);
    $display("simulation timed out after %0d cycles with %0d of %0d D beats seen",
             timeout_cycles, d_idx, n_d_beats);
    $display("test failed");
    $finish;
  end

endmodule

// ==== dv/tluh_reg_cases.txt ====
# A name opcode param size source address mask data  (request beat, hex fields)
# D name opcode error data                            (expected response beat, hex fields)
A put_get  0 0 2 1 00000010 f 12345678
D put_get  0 0 00000000
A put_get  4 0 2 2 00000010 f 00000000
D put_get  1 0 12345678
A partial  1 0 2 3 00000010 5 aabbccdd
D partial  0 0 00000000
A partial  4 0 2 4 00000010 f 00000000
D partial  1 0 12bb56dd
A burst    0 0 4 5 000000f8 f 11111111
A burst    0 0 4 5 000000f8 f 22222222
A burst    0 0 4 5 000000f8 f 33333333
A burst    0 0 4 5 000000f8 f 44444444
D burst    0 0 00000000
A burst    4 0 4 6 000000f8 f 00000000
D burst    1 0 11111111
D burst    1 0 22222222
D burst    1 0 33333333
D burst    1 0 44444444
A wrap     4 0 2 7 00000004 f 00000000
D wrap     1 0 44444444
A amo_add  0 0 2 8 00000020 f 00000005
D amo_add  0 0 00000000
A amo_add  2 4 2 9 00000020 f 0000000a
D amo_add  1 0 00000005
A amo_maxu 2 3 2 a 00000020 f 80000000
D amo_maxu 1 0 0000000f
A amo_min  2 0 2 b 00000020 f 00000003
D amo_min  1 0 80000000
A amo_xor  3 0 2 c 00000020 f ffff0000
D amo_xor  1 0 80000000
A amo_swap 3 3 2 d 00000020 f cafef00d
D amo_swap 1 0 7fff0000
A amo_swap 4 0 2 e 00000020 f 00000000
D amo_swap 1 0 cafef00d
A misalign 0 0 2 f 00000012 f deadbeef
D misalign 0 1 00000000
A misalign 4 0 2 0 00000010 f 00000000
D misalign 1 0 12bb56dd
A pfd_mask 0 0 2 1 00000010 3 deadbeef
D pfd_mask 0 1 00000000
A pfd_mask 4 0 2 2 00000010 f 00000000
D pfd_mask 1 0 12bb56dd
A amo_size 2 4 3 3 00000020 f 00000001
D amo_size 1 1 ffffffff
A amo_size 4 0 2 4 00000020 f 00000000
D amo_size 1 0 cafef00d
A range    4 0 2 5 00000100 f 00000000
D range    1 1 ffffffff

// ==== run_tluh_reg.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 --top-module tb_tluh_reg -f tluh_reg.f

out=$(./obj_dir/Vtb_tluh_reg)
echo "$out"

if echo "$out" | grep -qx "test passed"; then
  exit 0
fi
exit 1

// ==== src/tluh_adapter_reg.sv ====
module tluh_adapter_reg import tluh_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,

  // A channel
  input  logic       a_valid_i,
  input  tl_a_op_e   a_opcode_i,
  input  logic [2:0] a_param_i,
  input  tl_size_t   a_size_i,
  input  tl_source_t a_source_i,
  input  tl_addr_t   a_address_i,
  input  tl_mask_t   a_mask_i,
  input  tl_data_t   a_data_i,
  output logic       a_ready_o,

  // D channel
  output logic       d_valid_o,
  output tl_d_op_e   d_opcode_o,
  output tl_size_t   d_size_o,
  output tl_source_t d_source_o,
  output tl_data_t   d_data_o,
  output logic       d_error_o,
  input  logic       d_ready_i,

  // Checker, register file and ALU
  input  logic       tl_err_i,
  input  tl_data_t   rdata_i,
  input  logic       reg_err_i,
  input  tl_data_t   alu_result_i,
  output logic       re_o,
  output logic       we_o,
  output reg_addr_t  reg_addr_o,
  output tl_data_t   wdata_o,
  output tl_mask_t   be_o,
  output logic       alu_arith_o,
  output logic [2:0] alu_function_o,
  output tl_data_t   alu_op_a_o,
  output tl_data_t   alu_op_b_o
);

  typedef enum logic [2:0] {
    IDLE,
    GET_BEAT,   // Burst Get, next beat is read on each D handshake
    PUT_BEAT,   // Burst Put, collecting A beats
    ATOMIC_WB,  // ALU result goes back to the register
    RESP        // Last D beat waiting for d_ready
  } state_e;

  state_e     state_q;
  logic       a_ack, d_ack;
  logic       idle_acc, get_next;
  logic       is_get, is_put, is_atomic, rd_op;
  beat_cnt_t  a_beats, beats_q;
  reg_addr_t  a_addr_word, addr_q;
  logic       err_q;      // Request error, sticky over the burst
  logic       beat_err;
  logic       d_valid_q, d_err_q;
  tl_data_t   d_data_q, rsp_data, op_a_q;
  tl_source_t src_q;
  tl_size_t   size_q;
  tl_d_op_e   op_q;
  logic       arith_q;
  logic [2:0] func_q;

  assign a_ack    = a_valid_i & a_ready_o;
  assign d_ack    = d_valid_q & d_ready_i;
  assign idle_acc = (state_q == IDLE) & a_ack;
  assign get_next = (state_q == GET_BEAT) & d_ack;

  assign is_get    = a_opcode_i == Get;
  assign is_put    = a_opcode_i inside {PutFullData, PutPartialData};
  assign is_atomic = a_opcode_i inside {ArithmeticData, LogicalData};
  assign rd_op     = is_get | is_atomic;

  assign a_addr_word = {a_address_i[REG_AW-1:2], 2'b00};

  // Only Get and Put may burst
  always_comb begin
    a_beats = '0;
    if (is_get || is_put) begin
      case (a_size_i)
        3'd3:    a_beats = beat_cnt_t'(1);
        3'd4:    a_beats = beat_cnt_t'(3);
        default: a_beats = '0;
      endcase
    end
  end

  // Later Get beats no longer see the request on the A channel
  assign beat_err = (state_q == GET_BEAT) ? (err_q | reg_err_i) : (tl_err_i | reg_err_i);
  assign rsp_data = (idle_acc && !rd_op) ? '0 : (beat_err ? '1 : rdata_i);

  ////////////////////////////////////////////////////////////
  // Register strobes
  ////////////////////////////////////////////////////////////

  always_comb begin
    re_o       = 1'b0;
    we_o       = 1'b0;
    reg_addr_o = addr_q;
    wdata_o    = a_data_i;
    be_o       = a_mask_i;
    unique case (state_q)
      IDLE: begin
        reg_addr_o = a_addr_word;
        re_o       = a_ack & rd_op;  // Atomics read the old value here
        we_o       = a_ack & is_put & ~tl_err_i;
      end
      GET_BEAT: re_o = d_ack;
      PUT_BEAT: we_o = a_ack & ~tl_err_i;
      ATOMIC_WB: begin
        we_o    = ~err_q;
        wdata_o = alu_result_i;
        be_o    = '1;
      end
      default: ;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Sequencing
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= IDLE;
      beats_q   <= '0;
      addr_q    <= '0;
      err_q     <= 1'b0;
      d_valid_q <= 1'b0;
      d_err_q   <= 1'b0;
      arith_q   <= 1'b0;
      func_q    <= '0;
    end else begin
      unique case (state_q)
        IDLE: begin
          if (a_ack) begin
            beats_q <= a_beats;
            err_q   <= beat_err;
            addr_q  <= is_atomic ? a_addr_word : a_addr_word + reg_addr_t'(TL_DBW);
            if (is_atomic && !tl_err_i) begin
              arith_q <= a_opcode_i == ArithmeticData;
              func_q  <= a_param_i;
            end
            if (is_put && a_beats != '0) begin
              state_q <= PUT_BEAT;  // Ack comes after the last beat
            end else begin
              d_valid_q <= 1'b1;
              d_err_q   <= beat_err;
              if (is_atomic) begin
                state_q <= ATOMIC_WB;
              end else if (a_beats != '0) begin
                state_q <= GET_BEAT;
              end else begin
                state_q <= RESP;
              end
            end
          end
        end
        GET_BEAT: begin
          if (d_ack) begin
            d_err_q <= beat_err;
            beats_q <= beats_q - beat_cnt_t'(1);
            addr_q  <= addr_q + reg_addr_t'(TL_DBW);  // Wraps at the window end
            if (beats_q == beat_cnt_t'(1)) begin
              state_q <= RESP;
            end
          end
        end
        PUT_BEAT: begin
          if (a_ack) begin
            err_q   <= err_q | beat_err;
            beats_q <= beats_q - beat_cnt_t'(1);
            addr_q  <= addr_q + reg_addr_t'(TL_DBW);
            if (beats_q == beat_cnt_t'(1)) begin
              d_valid_q <= 1'b1;
              d_err_q   <= err_q | beat_err;
              state_q   <= RESP;
            end
          end
        end
        ATOMIC_WB: begin
          if (d_ack) begin
            d_valid_q <= 1'b0;
            state_q   <= IDLE;
          end else begin
            state_q <= RESP;
          end
        end
        RESP: begin
          if (d_ack) begin
            d_valid_q <= 1'b0;
            state_q   <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Response payload and request echo
  always_ff @(posedge clk_i) begin
    if (idle_acc || get_next) begin
      d_data_q <= rsp_data;
    end
    if (idle_acc) begin
      src_q  <= a_source_i;
      size_q <= a_size_i;
      op_q   <= rd_op ? AccessAckData : AccessAck;
      op_a_q <= a_data_i;
    end
  end

  assign a_ready_o  = (state_q == IDLE) || (state_q == PUT_BEAT);
  assign d_valid_o  = d_valid_q;
  assign d_opcode_o = op_q;
  assign d_size_o   = size_q;
  assign d_source_o = src_q;
  assign d_data_o   = d_data_q;
  assign d_error_o  = d_err_q;

  assign alu_arith_o    = arith_q;
  assign alu_function_o = func_q;
  assign alu_op_a_o     = op_a_q;
  assign alu_op_b_o     = d_data_q;  // Old value, also the D beat

  ////////////////////////////////////////////////////////////
  // Protocol checks
  ////////////////////////////////////////////////////////////

  a_d_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    d_valid_o && !d_ready_i |=> d_valid_o && $stable(d_data_o) && $stable(d_error_o)
  ) else $error("tluh_adapter_reg: D beat dropped or changed while stalled");

  a_ready_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    a_ready_o && d_valid_o |-> state_q == PUT_BEAT
  ) else $error("tluh_adapter_reg: A ready while a D beat is pending");

  a_beat_cnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q inside {GET_BEAT, PUT_BEAT} |-> beats_q != '0
  ) else $error("tluh_adapter_reg: beat count underflow");

endmodule

// ==== src/tluh_alu.sv ====
module tluh_alu import tluh_pkg::*; (
  input  logic       arith_i,     // ArithmeticData when high, LogicalData when low
  input  logic [2:0] function_i,
  input  tl_data_t   op_a_i,      // Request data
  input  tl_data_t   op_b_i,      // Old register value
  output tl_data_t   result_o
);

  logic     signed_lt;
  logic     unsigned_lt;
  tl_data_t sum;

  assign signed_lt   = $signed(op_a_i) < $signed(op_b_i);
  assign unsigned_lt = op_a_i < op_b_i;
  assign sum         = op_a_i + op_b_i;

  always_comb begin
    result_o = op_b_i;  // Unknown function leaves the word as it was
    if (arith_i) begin
      case (function_i)
        MIN:     result_o = signed_lt ? op_a_i : op_b_i;
        MAX:     result_o = signed_lt ? op_b_i : op_a_i;
        MINU:    result_o = unsigned_lt ? op_a_i : op_b_i;
        MAXU:    result_o = unsigned_lt ? op_b_i : op_a_i;
        ADD:     result_o = sum;
        default: result_o = op_b_i;
      endcase
    end else begin
      case (function_i)
        XOR:     result_o = op_a_i ^ op_b_i;
        OR:      result_o = op_a_i | op_b_i;
        AND:     result_o = op_a_i & op_b_i;
        SWAP:    result_o = op_a_i;
        default: result_o = op_b_i;
      endcase
    end
  end

  // The adapter only latches a function the checker let through
  always_comb begin
    if (arith_i) begin
      assert (function_i <= ADD)
        else $error("tluh_alu: arithmetic function %0d out of range", function_i);
    end
  end

endmodule

// ==== src/tluh_err.sv ====
module tluh_err import tluh_pkg::*; (
  input  tl_a_op_e   a_opcode_i,
  input  logic [2:0] a_param_i,
  input  tl_size_t   a_size_i,
  input  tl_addr_t   a_address_i,
  input  tl_mask_t   a_mask_i,
  output logic       err_o
);

  logic op_err;
  logic size_err;
  logic atomic_err;
  logic align_err;
  logic mask_err;
  logic range_err;

  assign op_err = !(a_opcode_i inside {PutFullData, PutPartialData, ArithmeticData,
                                       LogicalData, Get});

  // One beat up to TL_MAX_BEATS beats of a full word
  assign size_err = (a_size_i < tl_size_t'($clog2(TL_DBW))) ||
                    (a_size_i > tl_size_t'($clog2(TL_DBW * TL_MAX_BEATS)));

  // Atomics are word sized, function code must be a known one
  always_comb begin
    atomic_err = 1'b0;
    if (a_opcode_i == ArithmeticData) begin
      atomic_err = (a_size_i != tl_size_t'($clog2(TL_DBW))) || (a_param_i > ADD);
    end else if (a_opcode_i == LogicalData) begin
      atomic_err = (a_size_i != tl_size_t'($clog2(TL_DBW))) || (a_param_i > SWAP);
    end
  end

  // Every beat is a word; a burst may start on any word and wraps in the window
  assign align_err = a_address_i[$clog2(TL_DBW)-1:0] != '0;

  assign mask_err  = (a_opcode_i == PutFullData) && (a_mask_i != '1);

  // Nothing is decoded above the register window
  assign range_err = a_address_i >= tl_addr_t'(REG_DEPTH * TL_DBW);

  assign err_o = op_err | size_err | atomic_err | align_err | mask_err | range_err;

endmodule

// ==== src/tluh_pkg.sv ====
package tluh_pkg;

  ////////////////////////////////////////////////////////////
  // Bus and register window geometry
  ////////////////////////////////////////////////////////////

  localparam int TL_DW        = 32;  // Data bits per beat
  localparam int TL_DBW       = 4;   // Bytes per beat
  localparam int TL_AW        = 32;
  localparam int TL_SZW       = 3;
  localparam int TL_AIW       = 4;
  localparam int REG_AW       = 8;   // Byte address into the register window
  localparam int REG_DEPTH    = 64;  // Implemented words
  localparam int TL_MAX_BEATS = 4;

  typedef logic [TL_DW-1:0]  tl_data_t;
  typedef logic [TL_AW-1:0]  tl_addr_t;
  typedef logic [TL_DBW-1:0] tl_mask_t;
  typedef logic [TL_SZW-1:0] tl_size_t;   // log2 of transfer bytes
  typedef logic [TL_AIW-1:0] tl_source_t;
  typedef logic [REG_AW-1:0] reg_addr_t;

  // Beats still to go after the current one
  typedef logic [$clog2(TL_MAX_BEATS)-1:0] beat_cnt_t;

  ////////////////////////////////////////////////////////////
  // Channel opcodes
  ////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    PutFullData    = 3'h0,
    PutPartialData = 3'h1,
    ArithmeticData = 3'h2,
    LogicalData    = 3'h3,
    Get            = 3'h4
  } tl_a_op_e;

  typedef enum logic [2:0] {
    AccessAck     = 3'h0,
    AccessAckData = 3'h1
  } tl_d_op_e;

  ////////////////////////////////////////////////////////////
  // Atomic functions, carried in a_param
  ////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    MIN  = 3'h0,  // Signed
    MAX  = 3'h1,
    MINU = 3'h2,  // Unsigned
    MAXU = 3'h3,
    ADD  = 3'h4
  } alu_arith_e;

  typedef enum logic [2:0] {
    XOR  = 3'h0,
    OR   = 3'h1,
    AND  = 3'h2,
    SWAP = 3'h3   // Store request data
  } alu_logic_e;

endpackage

// ==== src/tluh_reg_file.sv ====
module tluh_reg_file import tluh_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      re_i,
  input  logic      we_i,
  input  reg_addr_t addr_i,
  input  tl_data_t  wdata_i,
  input  tl_mask_t  be_i,
  output tl_data_t  rdata_o,
  output logic      err_o
);

  tl_data_t                  mem [REG_DEPTH];
  logic [REG_AW-3:0]         word_idx;

  assign word_idx = addr_i[REG_AW-1:2];

  // Address only, so the adapter can gate its strobes on it
  assign err_o = int'(word_idx) >= REG_DEPTH;

  ////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < REG_DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (we_i && !err_o) begin
      for (int b = 0; b < TL_DBW; b++) begin
        if (be_i[b]) begin
          mem[word_idx][8*b +: 8] <= wdata_i[8*b +: 8];  // Byte lane b
        end
      end
    end
  end

  // Read port, idle bus reads as zero
  assign rdata_o = (re_i && !err_o) ? mem[word_idx] : '0;

  // The adapter never reads and writes in the same cycle, even across an atomic
  a_no_rw_overlap: assert property (
    @(posedge clk_i) disable iff (!rst_ni) !(re_i && we_i)
  ) else $error("tluh_reg_file: read and write strobes both high");

endmodule

// ==== src/tluh_reg_top.sv ====
module tluh_reg_top import tluh_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,

  input  logic       a_valid_i,
  input  tl_a_op_e   a_opcode_i,
  input  logic [2:0] a_param_i,
  input  tl_size_t   a_size_i,
  input  tl_source_t a_source_i,
  input  tl_addr_t   a_address_i,
  input  tl_mask_t   a_mask_i,
  input  tl_data_t   a_data_i,
  output logic       a_ready_o,

  output logic       d_valid_o,
  output tl_d_op_e   d_opcode_o,
  output tl_size_t   d_size_o,
  output tl_source_t d_source_o,
  output tl_data_t   d_data_o,
  output logic       d_error_o,
  input  logic       d_ready_i
);

  logic       tl_err;
  logic       re, we;
  reg_addr_t  reg_addr;
  tl_data_t   wdata, rdata;
  tl_mask_t   be;
  logic       reg_err;
  logic       alu_arith;
  logic [2:0] alu_function;
  tl_data_t   alu_op_a, alu_op_b, alu_result;

  tluh_adapter_reg u_adapter (
    .clk_i, .rst_ni,
    .a_valid_i, .a_opcode_i, .a_param_i, .a_size_i, .a_source_i,
    .a_address_i, .a_mask_i, .a_data_i, .a_ready_o,
    .d_valid_o, .d_opcode_o, .d_size_o, .d_source_o, .d_data_o, .d_error_o, .d_ready_i,
    .tl_err_i       (tl_err),
    .rdata_i        (rdata),
    .reg_err_i      (reg_err),
    .alu_result_i   (alu_result),
    .re_o           (re),
    .we_o           (we),
    .reg_addr_o     (reg_addr),
    .wdata_o        (wdata),
    .be_o           (be),
    .alu_arith_o    (alu_arith),
    .alu_function_o (alu_function),
    .alu_op_a_o     (alu_op_a),
    .alu_op_b_o     (alu_op_b)
  );

  tluh_err u_err (
    .a_opcode_i, .a_param_i, .a_size_i, .a_address_i, .a_mask_i,
    .err_o (tl_err)
  );

  tluh_alu u_alu (
    .arith_i    (alu_arith),
    .function_i (alu_function),
    .op_a_i     (alu_op_a),
    .op_b_i     (alu_op_b),
    .result_o   (alu_result)
  );

  tluh_reg_file u_reg_file (
    .clk_i, .rst_ni,
    .re_i    (re),
    .we_i    (we),
    .addr_i  (reg_addr),
    .wdata_i (wdata),
    .be_i    (be),
    .rdata_o (rdata),
    .err_o   (reg_err)
  );

endmodule

// ==== tluh_reg.f ====
src/tluh_pkg.sv
src/tluh_err.sv
src/tluh_alu.sv
src/tluh_reg_file.sv
src/tluh_adapter_reg.sv
src/tluh_reg_top.sv
dv/tb_tluh_reg.sv
